// ==== sources.f ====
design/dbus_pkg.sv
design/clint_pkg.sv
design/dbus_periph_decoder.sv
design/clint.sv
design/clint_subsys.sv
tb/clint_subsys_checker.sv
tb/clint_subsys_tb.sv

// ==== Makefile ====
# Verilator flow for the CLINT subsystem
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= clint_subsys_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_STR  ?= STATUS: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the log holds the pass line
sim: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/clint_subsys_tb.sv ====
`timescale 1ns/1ps
// --------------------------------------
// CLINT subsystem testbench
// Table of bus operations applied in a loop
// with readback, error and interrupt checks
// --------------------------------------
module clint_subsys_tb;
    import dbus_pkg::*;
    import clint_pkg::*;

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_WAIT} op_e;

    // One table entry
    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] w_data;
        logic [31:0] exp_data;
        logic [31:0] mask;
        logic        exp_err;
        logic        exp_tirq;
        logic        exp_sirq;
        logic        no_gap;
    } op_entry_s;

    // Entry flags, {err, timer irq, soft irq, no gap}
    localparam logic [3:0] NONE = 4'b0000;
    localparam logic [3:0] ERR  = 4'b1000;
    localparam logic [3:0] TIRQ = 4'b0100;
    localparam logic [3:0] SIRQ = 4'b0010;
    localparam logic [3:0] B2B  = 4'b0001;

    localparam logic [31:0] ALL = 32'hffff_ffff;
    localparam int ACK_LIMIT      = 4;
    localparam int IRQ_WAIT_LIMIT = 150;

    // Register addresses inside the CLINT window
    localparam logic [31:0] A_MSIP   = CLINT_BASE | {26'd0, CLINT_MSIP, 2'b00};
    localparam logic [31:0] A_RSVD   = CLINT_BASE | 32'h4;
    localparam logic [31:0] A_CMP_LO = CLINT_BASE | {26'd0, CLINT_MTIMECMP_LO, 2'b00};
    localparam logic [31:0] A_CMP_HI = CLINT_BASE | {26'd0, CLINT_MTIMECMP_HI, 2'b00};
    localparam logic [31:0] A_MT_LO  = CLINT_BASE | {26'd0, CLINT_MTIME_LO, 2'b00};
    localparam logic [31:0] A_MT_HI  = CLINT_BASE | {26'd0, CLINT_MTIME_HI, 2'b00};

    logic      clk;
    logic      rst_n;
    dbus_req_s req;
    dbus_rsp_s rsp;
    logic      timer_irq;
    logic      soft_irq;

    op_entry_s ops[$];
    integer    seed        = 32'hb7ca_33b1;
    int        errors      = 0;
    int        checks      = 0;
    int        cycles      = 0;
    int        cycle_limit = 0;

    clint_subsys u_clint_subsys (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbus_req_i  (req),
        .dbus_rsp_o  (rsp),
        .timer_irq_o (timer_irq),
        .soft_irq_o  (soft_irq)
    );

    bind clint_subsys clint_subsys_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbus_req_i  (dbus_req_i),
        .dbus_rsp_i  (dbus_rsp_o),
        .timer_irq_i (timer_irq_o),
        .soft_irq_i  (soft_irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Global cycle limit
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic void add_op(op_e op, logic [31:0] addr, logic [31:0] w_data,
                                   logic [31:0] exp_data, logic [31:0] mask,
                                   logic [3:0] flags);
        op_entry_s e;
        e.op       = op;
        e.addr     = addr;
        e.w_data   = w_data;
        e.exp_data = exp_data;
        e.mask     = mask;
        {e.exp_err, e.exp_tirq, e.exp_sirq, e.no_gap} = flags;
        ops.push_back(e);
    endfunction

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp, input logic [31:0] mask);
        checks++;
        if ((act & mask) !== (exp & mask)) begin
            $display("Mismatch %s: got %h, expected %h", name, act, exp);
            errors++;
        end
    endtask

    task automatic check_irqs(input op_entry_s e);
        check_value("timer_irq_o", 32'(timer_irq), 32'(e.exp_tirq), 32'h1);
        check_value("soft_irq_o", 32'(soft_irq), 32'(e.exp_sirq), 32'h1);
    endtask

    // Drive one request and hold it until ack
    task automatic bus_access(input op_entry_s e);
        int   waited;
        logic got_ack;
        waited     = 0;
        got_ack    = 1'b0;
        req.addr   = e.addr;
        req.w_data = e.w_data;
        req.w_en   = (e.op == OP_WR);
        req.cyc    = 1'b1;
        while (!got_ack && waited < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
            got_ack = (rsp.ack === 1'b1);
        end
        if (!got_ack) begin
            $display("Error: no ack for request to %h after %0d cycles", e.addr, ACK_LIMIT);
            errors++;
            #4;
            req.cyc = 1'b0;
        end else begin
            check_value("r_data", rsp.r_data, e.exp_data, e.mask);
            check_value("err", 32'(rsp.err), 32'(e.exp_err), 32'h1);
            // Ack seen at this edge, gone right after
            @(posedge clk);
            #1;
            check_value("ack", 32'(rsp.ack), 32'h0, 32'h1);
            #4;
            check_irqs(e);
        end
    endtask

    // Poll the timer interrupt level
    task automatic wait_timer_irq(input op_entry_s e);
        int waited;
        waited = 0;
        while (timer_irq !== e.exp_tirq && waited < IRQ_WAIT_LIMIT) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (timer_irq !== e.exp_tirq) begin
            $display("Error: timer interrupt did not reach level %0b within %0d cycles",
                     e.exp_tirq, IRQ_WAIT_LIMIT);
            errors++;
        end
        check_value("soft_irq_o", 32'(soft_irq), 32'(e.exp_sirq), 32'h1);
    endtask

    function automatic void fill_table();
        // Reset values, mtime low only needs an ack
        add_op(OP_RD, A_CMP_LO, 32'h0, 32'hffff_ffff, ALL, NONE);
        add_op(OP_RD, A_CMP_HI, 32'h0, 32'hffff_ffff, ALL, NONE);
        add_op(OP_RD, A_MT_HI, 32'h0, 32'h0, ALL, NONE);
        add_op(OP_RD, A_MT_LO, 32'h0, 32'h0, 32'h0, NONE);
        // Register readback
        add_op(OP_WR, A_CMP_LO, 32'h1234_5678, 32'h0, ALL, NONE);
        add_op(OP_RD, A_CMP_LO, 32'h0, 32'h1234_5678, ALL, NONE);
        add_op(OP_WR, A_CMP_HI, 32'hdead_beef, 32'h0, ALL, NONE);
        add_op(OP_RD, A_CMP_HI, 32'h0, 32'hdead_beef, ALL, NONE);
        add_op(OP_WR, A_MSIP, 32'hffff_fffe, 32'h0, ALL, NONE);
        add_op(OP_RD, A_MSIP, 32'h0, 32'h0, ALL, NONE);
        add_op(OP_WR, A_MSIP, 32'h0000_0003, 32'h0, ALL, SIRQ);
        add_op(OP_RD, A_MSIP, 32'h0, 32'h1, ALL, SIRQ);
        add_op(OP_WR, A_RSVD, 32'h5555_aaaa, 32'h0, ALL, SIRQ);
        add_op(OP_RD, A_RSVD, 32'h0, 32'h0, ALL, SIRQ);
        add_op(OP_WR, A_MSIP, 32'h0, 32'h0, ALL, NONE);
        // Timer interrupt, compare at 60
        add_op(OP_WR, A_MT_HI, 32'h0, 32'h0, ALL, NONE);
        add_op(OP_WR, A_MT_LO, 32'h0, 32'h0, ALL, NONE);
        add_op(OP_WR, A_CMP_HI, 32'h0, 32'h0, ALL, NONE);
        add_op(OP_WR, A_CMP_LO, 32'd60, 32'h0, ALL, NONE);
        add_op(OP_WAIT, 32'h0, 32'h0, 32'h0, 32'h0, TIRQ);
        add_op(OP_WR, A_CMP_HI, 32'hffff_ffff, 32'h0, ALL, NONE);
        add_op(OP_RD, A_MT_HI, 32'h0, 32'h0, ALL, NONE);
        // Software interrupt, only bit 0 counts
        add_op(OP_WR, A_MSIP, 32'h1, 32'h0, ALL, SIRQ);
        add_op(OP_RD, A_MSIP, 32'h0, 32'h1, ALL, SIRQ);
        add_op(OP_WR, A_MSIP, 32'h0, 32'h0, ALL, NONE);
        add_op(OP_WR, A_MSIP, 32'h2, 32'h0, ALL, NONE);
        add_op(OP_RD, A_MSIP, 32'h0, 32'h0, ALL, NONE);
        // Unmapped accesses, then compare value unchanged
        add_op(OP_RD, 32'h1000_0000, 32'h0, 32'h0, ALL, ERR);
        add_op(OP_WR, CLINT_BASE + 32'h40, 32'ha5a5_a5a5, 32'h0, ALL, ERR);
        add_op(OP_RD, A_CMP_LO, 32'h0, 32'd60, ALL, NONE);
        add_op(OP_RD, A_CMP_HI, 32'h0, 32'hffff_ffff, ALL, NONE);
        // Back-to-back traffic, mapped and unmapped mixed
        add_op(OP_WR, A_CMP_LO, 32'h0bad_f00d, 32'h0, ALL, B2B);
        add_op(OP_RD, A_CMP_LO, 32'h0, 32'h0bad_f00d, ALL, B2B);
        add_op(OP_WR, A_MSIP, 32'h1, 32'h0, ALL, SIRQ | B2B);
        add_op(OP_RD, 32'h2000_0000, 32'h0, 32'h0, ALL, ERR | SIRQ | B2B);
        add_op(OP_RD, A_MSIP, 32'h0, 32'h1, ALL, SIRQ | B2B);
        add_op(OP_WR, A_MSIP, 32'h0, 32'h0, ALL, B2B);
        add_op(OP_RD, A_CMP_HI, 32'h0, 32'hffff_ffff, ALL, B2B);
        // Random gaps again
        add_op(OP_WR, A_CMP_HI, 32'h0000_0001, 32'h0, ALL, NONE);
        add_op(OP_RD, A_CMP_HI, 32'h0, 32'h0000_0001, ALL, NONE);
    endfunction

    initial begin : main
        int gap;
        int n_wait;
        req    = '0;
        rst_n  = 1'b0;
        n_wait = 0;
        fill_table();
        foreach (ops[i]) begin
            if (ops[i].op == OP_WAIT) begin
                n_wait++;
            end
        end
        cycle_limit = ops.size() * 8 + 200 * n_wait;

        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;

        foreach (ops[i]) begin
            if (!ops[i].no_gap) begin
                req.cyc = 1'b0;
                gap = {$random(seed)} % 4;
                repeat (gap) begin
                    @(posedge clk);
                    #5;
                end
            end
            if (ops[i].op == OP_WAIT) begin
                wait_timer_irq(ops[i]);
            end else begin
                bus_access(ops[i]);
            end
        end
        req.cyc = 1'b0;

        $display("Run complete: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, u_clint_subsys.u_checker.fails);
        if (errors == 0 && u_clint_subsys.u_checker.fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb/clint_subsys_checker.sv ====
`timescale 1ns/1ps
// --------------------------------------
// CLINT subsystem checker
// Handshake and interrupt assertions
// --------------------------------------
module clint_subsys_checker (
    input logic                clk,
    input logic                rst_n,
    input dbus_pkg::dbus_req_s dbus_req_i,
    input dbus_pkg::dbus_rsp_s dbus_rsp_i,
    input logic                timer_irq_i,
    input logic                soft_irq_i
);

    // Failed assertions so far
    int fails = 0;

    // Ack is a single-cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_rsp_i.ack |=> !dbus_rsp_i.ack)
        else begin
            $error("ack high in two consecutive cycles");
            fails++;
        end

    // Ack only answers a cycle seen one edge earlier
    ack_after_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_rsp_i.ack |-> $past(dbus_req_i.cyc))
        else begin
            $error("ack without cyc in the previous cycle");
            fails++;
        end

    err_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_rsp_i.err |-> dbus_rsp_i.ack)
        else begin
            $error("err high without ack");
            fails++;
        end

    // Interrupts known and quiet right out of reset
    irq_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !$isunknown({timer_irq_i, soft_irq_i}) && !timer_irq_i && !soft_irq_i)
        else begin
            $error("interrupt outputs not low after reset release");
            fails++;
        end

endmodule

// ==== design/clint_subsys.sv ====
`timescale 1ns/1ps
// --------------------------------------
// CLINT subsystem top
// Peripheral decoder in front of the CLINT
// --------------------------------------
module clint_subsys (
    input  logic                clk,
    input  logic                rst_n,

    // Data bus from the core
    input  dbus_pkg::dbus_req_s dbus_req_i,
    output dbus_pkg::dbus_rsp_s dbus_rsp_o,

    // Interrupts to the core
    output logic                timer_irq_o,
    output logic                soft_irq_o
);
    import dbus_pkg::*;

    // Decoder to CLINT
    dbus_req_s clint_req;
    dbus_rsp_s clint_rsp;

    // --------------------------------------
    // Address decoder
    // --------------------------------------
    dbus_periph_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbus_req_i  (dbus_req_i),
        .dbus_rsp_o  (dbus_rsp_o),
        .clint_sel_o (),
        .clint_req_o (clint_req),
        .clint_rsp_i (clint_rsp)
    );

    // --------------------------------------
    // Core-local interruptor
    // --------------------------------------
    clint u_clint (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbus_req_i  (clint_req),
        .dbus_rsp_o  (clint_rsp),
        .timer_irq_o (timer_irq_o),
        .soft_irq_o  (soft_irq_o)
    );

endmodule

// ==== design/clint.sv ====
`timescale 1ns/1ps
// --------------------------------------
// Core-local interruptor
// mtime, mtimecmp and msip on the data bus,
// timer and software interrupt generation
// --------------------------------------
module clint (
    input  logic                clk,
    input  logic                rst_n,

    // Data bus, already qualified by the decoder
    input  dbus_pkg::dbus_req_s dbus_req_i,
    output dbus_pkg::dbus_rsp_s dbus_rsp_o,

    // Interrupts to the core
    output logic                timer_irq_o,
    output logic                soft_irq_o
);
    import dbus_pkg::*;
    import clint_pkg::*;

    // Bus side
    clint_reg_e         reg_sel;
    logic               rd_req;
    logic               wr_req;
    logic [DBUS_DW-1:0] rd_data;
    logic               ack_q;
    logic [DBUS_DW-1:0] r_data_q;

    // Write flags per register
    logic               msip_wr;
    logic               mtime_lo_wr;
    logic               mtime_hi_wr;
    logic               mtimecmp_lo_wr;
    logic               mtimecmp_hi_wr;

    // Register state
    logic [MTIME_W-1:0] mtime_q;
    logic [MTIME_W-1:0] mtime_d;
    logic [MTIME_W-1:0] mtimecmp_q;
    logic [MTIME_W-1:0] mtimecmp_d;
    logic               msip_q;
    logic               timer_irq_q;

    // --------------------------------------
    // Request qualification
    // --------------------------------------

    // Word offset within the window
    assign reg_sel = clint_reg_e'(dbus_req_i.addr[5:2]);

    // Blocked during own ack so nothing happens twice
    assign rd_req = dbus_req_i.cyc & ~dbus_req_i.w_en & ~ack_q;
    assign wr_req = dbus_req_i.cyc &  dbus_req_i.w_en & ~ack_q;

    // Read mux, unlisted offsets read zero
    always_comb begin
        rd_data = '0;
        case (reg_sel)
            CLINT_MSIP:        rd_data = {{(DBUS_DW-1){1'b0}}, msip_q};
            CLINT_MTIMECMP_LO: rd_data = mtimecmp_q[DBUS_DW-1:0];
            CLINT_MTIMECMP_HI: rd_data = mtimecmp_q[MTIME_W-1:DBUS_DW];
            CLINT_MTIME_LO:    rd_data = mtime_q[DBUS_DW-1:0];
            CLINT_MTIME_HI:    rd_data = mtime_q[MTIME_W-1:DBUS_DW];
            default:           rd_data = '0;
        endcase
    end

    // Write decode, unlisted offsets ignored
    always_comb begin
        msip_wr        = 1'b0;
        mtime_lo_wr    = 1'b0;
        mtime_hi_wr    = 1'b0;
        mtimecmp_lo_wr = 1'b0;
        mtimecmp_hi_wr = 1'b0;
        if (wr_req) begin
            case (reg_sel)
                CLINT_MSIP:        msip_wr        = 1'b1;
                CLINT_MTIMECMP_LO: mtimecmp_lo_wr = 1'b1;
                CLINT_MTIMECMP_HI: mtimecmp_hi_wr = 1'b1;
                CLINT_MTIME_LO:    mtime_lo_wr    = 1'b1;
                CLINT_MTIME_HI:    mtime_hi_wr    = 1'b1;
                default:           ;
            endcase
        end
    end

    // --------------------------------------
    // Timer registers
    // --------------------------------------

    // Half-load on write, otherwise count
    always_comb begin
        if (mtime_lo_wr) begin
            mtime_d = {mtime_q[MTIME_W-1:DBUS_DW], dbus_req_i.w_data};
        end else if (mtime_hi_wr) begin
            mtime_d = {dbus_req_i.w_data, mtime_q[DBUS_DW-1:0]};
        end else begin
            mtime_d = mtime_q + 1'b1;
        end
    end

    // Compare value holds unless written
    always_comb begin
        mtimecmp_d = mtimecmp_q;
        if (mtimecmp_lo_wr) begin
            mtimecmp_d[DBUS_DW-1:0] = dbus_req_i.w_data;
        end
        if (mtimecmp_hi_wr) begin
            mtimecmp_d[MTIME_W-1:DBUS_DW] = dbus_req_i.w_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q     <= MTIME_RST;
            mtimecmp_q  <= MTIMECMP_RST;
            msip_q      <= 1'b0;
            timer_irq_q <= 1'b0;
        end else begin
            mtime_q     <= mtime_d;
            mtimecmp_q  <= mtimecmp_d;
            // Only bit 0 of msip is implemented
            if (msip_wr) begin
                msip_q <= dbus_req_i.w_data[0];
            end
            // Registered compare, one cycle behind
            timer_irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    // --------------------------------------
    // Bus response
    // --------------------------------------

    // Single-cycle ack for reads and writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            r_data_q <= '0;
        end else begin
            ack_q    <= rd_req | wr_req;
            r_data_q <= rd_req ? rd_data : '0;
        end
    end

    // CLINT never reports an error
    always_comb begin
        dbus_rsp_o        = '0;
        dbus_rsp_o.r_data = r_data_q;
        dbus_rsp_o.ack    = ack_q;
    end

    assign timer_irq_o = timer_irq_q;
    assign soft_irq_o  = msip_q;

endmodule

// ==== design/dbus_periph_decoder.sv ====
`timescale 1ns/1ps
// --------------------------------------
// Data-bus peripheral decoder
// Selects the CLINT by address, steers its response
// to the core, answers unmapped requests with err
// --------------------------------------
module dbus_periph_decoder (
    input  logic                clk,
    input  logic                rst_n,

    // Core side
    input  dbus_pkg::dbus_req_s dbus_req_i,
    output dbus_pkg::dbus_rsp_s dbus_rsp_o,

    // CLINT side
    output logic                clint_sel_o,
    output dbus_pkg::dbus_req_s clint_req_o,
    input  dbus_pkg::dbus_rsp_s clint_rsp_i
);
    import dbus_pkg::*;

    logic      unmapped_cyc;
    logic      err_ack_q;
    dbus_rsp_s err_rsp;

    // --------------------------------------
    // Address decode
    // --------------------------------------

    // CLINT window match
    assign clint_sel_o = ((dbus_req_i.addr & CLINT_MASK) == CLINT_BASE);

    // Forward request, cyc only when selected
    always_comb begin
        clint_req_o     = dbus_req_i;
        clint_req_o.cyc = dbus_req_i.cyc & clint_sel_o;
    end

    // Active cycle outside every mapped region
    assign unmapped_cyc = dbus_req_i.cyc & ~clint_sel_o;

    // --------------------------------------
    // Error response for unmapped requests
    // --------------------------------------

    // One-cycle error ack, same latency as CLINT
    // No re-ack while own ack is set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= unmapped_cyc & ~err_ack_q;
        end
    end

    // Error response carries no data
    always_comb begin
        err_rsp        = '0;
        err_rsp.ack    = err_ack_q;
        err_rsp.err    = err_ack_q;
    end

    // --------------------------------------
    // Response steering
    // --------------------------------------

    // Request is held through its ack cycle,
    // so the live select picks the responder
    always_comb begin
        if (clint_sel_o) begin
            dbus_rsp_o = clint_rsp_i;
        end else begin
            dbus_rsp_o = err_rsp;
        end
    end

endmodule

// ==== design/clint_pkg.sv ====
// --------------------------------------
// CLINT definitions
// Register word offsets, timer width and
// reset values of the timer registers
// --------------------------------------
package clint_pkg;

    // Machine timer width
    localparam int unsigned MTIME_W = 64;

    // Timer reset values
    // mtimecmp all ones keeps the timer interrupt off
    localparam logic [MTIME_W-1:0] MTIME_RST    = '0;
    localparam logic [MTIME_W-1:0] MTIMECMP_RST = '1;

    // --------------------------------------
    // Register map, word offset from addr[5:2]
    // --------------------------------------
    typedef enum logic [3:0] {
        CLINT_MSIP        = 4'd0,
        CLINT_MTIMECMP_LO = 4'd2,
        CLINT_MTIMECMP_HI = 4'd3,
        CLINT_MTIME_LO    = 4'd4,
        CLINT_MTIME_HI    = 4'd5
    } clint_reg_e;

endpackage

// ==== design/dbus_pkg.sv ====
// --------------------------------------
// Data-bus definitions
// Request and response structs for the core data bus
// and the peripheral address map
// --------------------------------------
package dbus_pkg;

    // Bus widths
    localparam int unsigned DBUS_AW = 32;
    localparam int unsigned DBUS_DW = 32;

    // --------------------------------------
    // Peripheral address map
    // --------------------------------------

    // CLINT occupies a 64-byte window
    localparam logic [DBUS_AW-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [DBUS_AW-1:0] CLINT_MASK = 32'hffff_ffc0;

    // Request from the core, held until ack
    typedef struct packed {
        logic [DBUS_AW-1:0] addr;
        logic [DBUS_DW-1:0] w_data;
        logic               w_en;
        logic               cyc;
    } dbus_req_s;

    // Response back to the core
    // r_data is zero unless ack on a read
    typedef struct packed {
        logic [DBUS_DW-1:0] r_data;
        logic               ack;
        logic               err;
    } dbus_rsp_s;

endpackage
